//--- verilog/roce_cfg.svh
// RoCE transport configuration: widths, queue-pair count and network word layout
`ifndef ROCE_CFG_SVH
`define ROCE_CFG_SVH

// Field widths
`define ROCE_QPN_BITS         2
`define ROCE_NUM_QP           4
`define ROCE_PSN_BITS         24
`define ROCE_LEN_BITS         16
`define ROCE_VADDR_BITS       32
`define ROCE_NET_BITS         64
`define ROCE_OPC_BITS         5
`define ROCE_CNT_BITS         32

// Work requests in flight before the send queue stalls
`define ROCE_MAX_OUTSTANDING  4

// Network word layout, low bit of each field
// opcode [63:59], QPN [57:56], PSN [47:24], length [15:0]
`define ROCE_OPC_LSB          59
`define ROCE_QPN_LSB          56
`define ROCE_PSN_LSB          24
`define ROCE_LEN_LSB          0

`endif

//--- verilog/roce_pkg.sv
// Shared RoCE types: field vectors and the transport opcode enum
`include "roce_cfg.svh"

package roce_pkg;

  // Queue pair number
  typedef logic [`ROCE_QPN_BITS-1:0]   qpn_t;

  // Packet sequence number
  typedef logic [`ROCE_PSN_BITS-1:0]   psn_t;

  // Request length in bytes
  typedef logic [`ROCE_LEN_BITS-1:0]   len_t;

  // User virtual address
  typedef logic [`ROCE_VADDR_BITS-1:0] vaddr_t;

  // Single-beat network word
  typedef logic [`ROCE_NET_BITS-1:0]   net_word_t;

  // Debug counter
  typedef logic [`ROCE_CNT_BITS-1:0]   cnt_t;

  // RC opcodes, only the first three come from the send queue
  typedef enum logic [`ROCE_OPC_BITS-1:0] {
    RC_SEND     = 5'd0,
    RC_WRITE    = 5'd10,
    RC_READ_REQ = 5'd12,
    RC_ACK      = 5'd17
  } roce_opcode_t;

endpackage

//--- verilog/rdma_flow.sv
// Flow control: caps work requests in flight and returns acks to the user
`timescale 1ns/1ps
`include "roce_cfg.svh"

module rdma_flow import roce_pkg::*; (
  input  logic         nclk,
  input  logic         arst_n,

  // Send queue from the user
  input  logic         s_sq_valid,
  output logic         s_sq_ready,
  input  roce_opcode_t s_sq_opcode,
  input  qpn_t         s_sq_qpn,
  input  vaddr_t       s_sq_vaddr,
  input  len_t         s_sq_len,

  // Send queue to the transmit engine
  output logic         m_sq_valid,
  input  logic         m_sq_ready,
  output roce_opcode_t m_sq_opcode,
  output qpn_t         m_sq_qpn,
  output vaddr_t       m_sq_vaddr,
  output len_t         m_sq_len,

  // Checked acks from the receive engine
  input  logic         s_ack_valid,
  output logic         s_ack_ready,
  input  qpn_t         s_ack_qpn,
  input  psn_t         s_ack_psn,

  // Acks to the user
  output logic         m_ack_valid,
  input  logic         m_ack_ready,
  output qpn_t         m_ack_qpn,
  output psn_t         m_ack_psn
);

  localparam int FLIGHT_BITS = $clog2(`ROCE_MAX_OUTSTANDING + 1);
  localparam logic [FLIGHT_BITS-1:0] FLIGHT_MAX = FLIGHT_BITS'(`ROCE_MAX_OUTSTANDING);

  logic [FLIGHT_BITS-1:0] inflight;
  logic                   at_limit;
  logic                   sq_fire;
  logic                   ack_fire;

  assign at_limit = (inflight == FLIGHT_MAX);

  // Send path, only the limit gate sits in the way
  assign m_sq_valid  = s_sq_valid & ~at_limit;
  assign s_sq_ready  = m_sq_ready & ~at_limit;
  assign m_sq_opcode = s_sq_opcode;
  assign m_sq_qpn    = s_sq_qpn;
  assign m_sq_vaddr  = s_sq_vaddr;
  assign m_sq_len    = s_sq_len;

  // Ack path straight through
  assign m_ack_valid = s_ack_valid;
  assign s_ack_ready = m_ack_ready;
  assign m_ack_qpn   = s_ack_qpn;
  assign m_ack_psn   = s_ack_psn;

  assign sq_fire  = m_sq_valid & m_sq_ready;
  assign ack_fire = m_ack_valid & m_ack_ready;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      inflight <= '0;
    end else if (sq_fire && !ack_fire) begin
      inflight <= inflight + 1'b1;
    end else if (ack_fire && !sq_fire) begin
      inflight <= inflight - 1'b1;
    end
  end

  a_flight_cap: assert property (@(posedge nclk) disable iff (!arst_n)
    inflight <= FLIGHT_MAX);

  // An ack to the user must match an earlier send
  a_no_underflow: assert property (@(posedge nclk) disable iff (!arst_n)
    (ack_fire && !sq_fire) |-> (inflight != '0));

endmodule

//--- verilog/roce_tx_engine.sv
// Transmit engine: per-QP PSN assignment and single-word header output
`timescale 1ns/1ps
`include "roce_cfg.svh"

module roce_tx_engine import roce_pkg::*; (
  input  logic         nclk,
  input  logic         arst_n,

  // Send queue after flow control
  input  logic         sq_valid,
  output logic         sq_ready,
  input  roce_opcode_t sq_opcode,
  input  qpn_t         sq_qpn,
  input  vaddr_t       sq_vaddr,
  input  len_t         sq_len,

  // Network transmit
  output logic         tx_valid,
  input  logic         tx_ready,
  output net_word_t    tx_data,

  // Debug
  output logic         tx_pkt_count_valid,
  output cnt_t         tx_pkt_count_data
);

  psn_t      psn_tab [`ROCE_NUM_QP];
  net_word_t hdr;
  logic      sq_fire;
  logic      tx_fire;

  // Output register is free when empty or draining this cycle
  assign sq_ready = ~tx_valid | tx_ready;
  assign sq_fire  = sq_valid & sq_ready;
  assign tx_fire  = tx_valid & tx_ready;

  // Header word, unused bits stay zero
  // sq_vaddr is only needed once payload fetch is added
  always_comb begin
    hdr = '0;
    hdr[`ROCE_OPC_LSB +: `ROCE_OPC_BITS] = sq_opcode;
    hdr[`ROCE_QPN_LSB +: `ROCE_QPN_BITS] = sq_qpn;
    hdr[`ROCE_PSN_LSB +: `ROCE_PSN_BITS] = psn_tab[sq_qpn];
    hdr[`ROCE_LEN_LSB +: `ROCE_LEN_BITS] = sq_len;
  end

  // Next PSN per queue pair
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `ROCE_NUM_QP; i++) begin
        psn_tab[i] <= '0;
      end
    end else if (sq_fire) begin
      psn_tab[sq_qpn] <= psn_tab[sq_qpn] + 1'b1;
    end
  end

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_valid <= 1'b0;
    end else if (sq_fire) begin
      tx_valid <= 1'b1;
    end else if (tx_ready) begin
      tx_valid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge nclk) begin
    if (sq_fire) begin
      tx_data <= hdr;
    end
  end

  // Transmitted packets
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_pkt_count_data  <= '0;
      tx_pkt_count_valid <= 1'b0;
    end else begin
      tx_pkt_count_valid <= tx_fire;
      if (tx_fire) begin
        tx_pkt_count_data <= tx_pkt_count_data + 1'b1;
      end
    end
  end

  a_tx_hold: assert property (@(posedge nclk) disable iff (!arst_n)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

//--- verilog/roce_rx_engine.sv
// Receive engine: ack PSN check, drop handling and receive counters
`timescale 1ns/1ps
`include "roce_cfg.svh"

module roce_rx_engine import roce_pkg::*; (
  input  logic      nclk,
  input  logic      arst_n,

  // Network receive
  input  logic      rx_valid,
  output logic      rx_ready,
  input  net_word_t rx_data,

  // Checked acks
  output logic      ack_valid,
  input  logic      ack_ready,
  output qpn_t      ack_qpn,
  output psn_t      ack_psn,

  // Debug
  output logic      rx_pkt_count_valid,
  output cnt_t      rx_pkt_count_data,
  output logic      psn_drop_count_valid,
  output cnt_t      psn_drop_count_data
);

  typedef enum logic {
    RX_IDLE,
    RX_HOLD
  } rx_state_t;

  rx_state_t    state_q;
  rx_state_t    state_d;
  psn_t         exp_tab [`ROCE_NUM_QP];
  roce_opcode_t rx_opc;
  qpn_t         rx_qpn;
  psn_t         rx_psn;
  logic         keep;
  logic         rx_fire;

  // Field extraction
  assign rx_opc = roce_opcode_t'(rx_data[`ROCE_OPC_LSB +: `ROCE_OPC_BITS]);
  assign rx_qpn = rx_data[`ROCE_QPN_LSB +: `ROCE_QPN_BITS];
  assign rx_psn = rx_data[`ROCE_PSN_LSB +: `ROCE_PSN_BITS];

  // In-order ack for its QP
  assign keep = (rx_opc == RC_ACK) && (rx_psn == exp_tab[rx_qpn]);

  // Words to drop never wait on the ack register
  assign rx_ready  = keep ? ((state_q == RX_IDLE) || ack_ready) : 1'b1;
  assign rx_fire   = rx_valid & rx_ready;
  assign ack_valid = (state_q == RX_HOLD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: begin
        if (rx_fire && keep) begin
          state_d = RX_HOLD;
        end
      end
      RX_HOLD: begin
        // Reload in the same cycle as the drain
        if (ack_ready && !(rx_fire && keep)) begin
          state_d = RX_IDLE;
        end
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= RX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Expected PSN per queue pair
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `ROCE_NUM_QP; i++) begin
        exp_tab[i] <= '0;
      end
    end else if (rx_fire && keep) begin
      exp_tab[rx_qpn] <= exp_tab[rx_qpn] + 1'b1;
    end
  end

  always_ff @(posedge nclk) begin
    if (rx_fire && keep) begin
      ack_qpn <= rx_qpn;
      ack_psn <= rx_psn;
    end
  end

  // Received and dropped packets
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      rx_pkt_count_data    <= '0;
      rx_pkt_count_valid   <= 1'b0;
      psn_drop_count_data  <= '0;
      psn_drop_count_valid <= 1'b0;
    end else begin
      rx_pkt_count_valid   <= rx_fire;
      psn_drop_count_valid <= rx_fire & ~keep;
      if (rx_fire) begin
        rx_pkt_count_data <= rx_pkt_count_data + 1'b1;
      end
      if (rx_fire && !keep) begin
        psn_drop_count_data <= psn_drop_count_data + 1'b1;
      end
    end
  end

  a_ack_source: assert property (@(posedge nclk) disable iff (!arst_n)
    $rose(ack_valid) |-> $past(rx_fire && keep));

endmodule

//--- verilog/roce_stack.sv
// RoCE stack top: flow control between the user queues and both engines
`timescale 1ns/1ps
`include "roce_cfg.svh"

module roce_stack import roce_pkg::*; (
  input  logic         nclk,
  input  logic         arst_n,

  // User send queue
  input  logic         sq_valid,
  output logic         sq_ready,
  input  roce_opcode_t sq_opcode,
  input  qpn_t         sq_qpn,
  input  vaddr_t       sq_vaddr,
  input  len_t         sq_len,

  // User acks
  output logic         ack_valid,
  input  logic         ack_ready,
  output qpn_t         ack_qpn,
  output psn_t         ack_psn,

  // Network
  output logic         tx_valid,
  input  logic         tx_ready,
  output net_word_t    tx_data,
  input  logic         rx_valid,
  output logic         rx_ready,
  input  net_word_t    rx_data,

  // Debug
  output logic         rx_pkt_count_valid,
  output cnt_t         rx_pkt_count_data,
  output logic         tx_pkt_count_valid,
  output cnt_t         tx_pkt_count_data,
  output logic         psn_drop_count_valid,
  output cnt_t         psn_drop_count_data
);

  logic         fl_sq_valid;
  logic         fl_sq_ready;
  roce_opcode_t fl_sq_opcode;
  qpn_t         fl_sq_qpn;
  vaddr_t       fl_sq_vaddr;
  len_t         fl_sq_len;

  logic         rx_ack_valid;
  logic         rx_ack_ready;
  qpn_t         rx_ack_qpn;
  psn_t         rx_ack_psn;

  rdma_flow inst_rdma_flow (
    .nclk        (nclk),
    .arst_n      (arst_n),
    .s_sq_valid  (sq_valid),
    .s_sq_ready  (sq_ready),
    .s_sq_opcode (sq_opcode),
    .s_sq_qpn    (sq_qpn),
    .s_sq_vaddr  (sq_vaddr),
    .s_sq_len    (sq_len),
    .m_sq_valid  (fl_sq_valid),
    .m_sq_ready  (fl_sq_ready),
    .m_sq_opcode (fl_sq_opcode),
    .m_sq_qpn    (fl_sq_qpn),
    .m_sq_vaddr  (fl_sq_vaddr),
    .m_sq_len    (fl_sq_len),
    .s_ack_valid (rx_ack_valid),
    .s_ack_ready (rx_ack_ready),
    .s_ack_qpn   (rx_ack_qpn),
    .s_ack_psn   (rx_ack_psn),
    .m_ack_valid (ack_valid),
    .m_ack_ready (ack_ready),
    .m_ack_qpn   (ack_qpn),
    .m_ack_psn   (ack_psn)
  );

  roce_tx_engine inst_tx (
    .nclk               (nclk),
    .arst_n             (arst_n),
    .sq_valid           (fl_sq_valid),
    .sq_ready           (fl_sq_ready),
    .sq_opcode          (fl_sq_opcode),
    .sq_qpn             (fl_sq_qpn),
    .sq_vaddr           (fl_sq_vaddr),
    .sq_len             (fl_sq_len),
    .tx_valid           (tx_valid),
    .tx_ready           (tx_ready),
    .tx_data            (tx_data),
    .tx_pkt_count_valid (tx_pkt_count_valid),
    .tx_pkt_count_data  (tx_pkt_count_data)
  );

  roce_rx_engine inst_rx (
    .nclk                 (nclk),
    .arst_n               (arst_n),
    .rx_valid             (rx_valid),
    .rx_ready             (rx_ready),
    .rx_data              (rx_data),
    .ack_valid            (rx_ack_valid),
    .ack_ready            (rx_ack_ready),
    .ack_qpn              (rx_ack_qpn),
    .ack_psn              (rx_ack_psn),
    .rx_pkt_count_valid   (rx_pkt_count_valid),
    .rx_pkt_count_data    (rx_pkt_count_data),
    .psn_drop_count_valid (psn_drop_count_valid),
    .psn_drop_count_data  (psn_drop_count_data)
  );

endmodule

//--- verification/roce_stack_tb.sv
// RoCE stack testbench: runs the vector file and checks every response
`timescale 1ns/1ps
`include "roce_cfg.svh"

module roce_stack_tb import roce_pkg::*; ();

  logic         nclk;
  logic         arst_n;
  logic         sq_valid;
  logic         sq_ready;
  roce_opcode_t sq_opcode;
  qpn_t         sq_qpn;
  vaddr_t       sq_vaddr;
  len_t         sq_len;
  logic         ack_valid;
  logic         ack_ready;
  qpn_t         ack_qpn;
  psn_t         ack_psn;
  logic         tx_valid;
  logic         tx_ready;
  net_word_t    tx_data;
  logic         rx_valid;
  logic         rx_ready;
  net_word_t    rx_data;
  logic         rx_pkt_count_valid;
  cnt_t         rx_pkt_count_data;
  logic         tx_pkt_count_valid;
  cnt_t         tx_pkt_count_data;
  logic         psn_drop_count_valid;
  cnt_t         psn_drop_count_data;

  // Vector line: kind, opcode, qpn, psn, len, addr, test
  logic [95:0] vec [0:63];
  int          nlines;
  int          cycles;
  int          limit;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests_run;
  logic [7:0]  cur_test;
  logic [3:0]  line_kind;
  logic [7:0]  line_opc;
  logic [3:0]  line_qpn;
  logic [23:0] line_psn;
  logic [15:0] line_len;
  logic [31:0] line_addr;
  logic [7:0]  line_test;
  logic [31:0] rng;

  // Reference model state
  psn_t        tx_psn [`ROCE_NUM_QP];
  psn_t        rx_psn [`ROCE_NUM_QP];
  logic [25:0] ack_q [$];
  cnt_t        tx_cnt;
  cnt_t        rx_cnt;
  cnt_t        drop_cnt;

  roce_stack dut0 (.*);

  always #50 nclk = ~nclk;

  // Run limit from the number of vector lines
  always @(posedge nclk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, test %0d never finished", cycles, line_test);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic net_word_t build_word(input logic [4:0] opc, input qpn_t qpn,
                                           input psn_t psn, input len_t len);
    net_word_t w;
    w = '0;
    w[`ROCE_OPC_LSB +: `ROCE_OPC_BITS] = opc;
    w[`ROCE_QPN_LSB +: `ROCE_QPN_BITS] = qpn;
    w[`ROCE_PSN_LSB +: `ROCE_PSN_BITS] = psn;
    w[`ROCE_LEN_LSB +: `ROCE_LEN_BITS] = len;
    return w;
  endfunction

  task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error test %0d: %s expected %0h actual %0h", cur_test, what, exp, act);
    test_errors = test_errors + 1;
  endtask

  // Ready level for a sink, random only in the stall test
  function automatic logic sink_ready();
    if (cur_test == 8'd5) begin
      rng = lcg_next(rng);
      return rng[16];
    end
    return 1'b1;
  endfunction

  task automatic drive_idle();
    sq_valid  = 1'b0;
    rx_valid  = 1'b0;
    tx_ready  = 1'b0;
    ack_ready = 1'b0;
  endtask

  task automatic send_request();
    @(negedge nclk);
    drive_idle();
    sq_valid  = 1'b1;
    sq_opcode = roce_opcode_t'(line_opc[4:0]);
    sq_qpn    = line_qpn[1:0];
    sq_vaddr  = line_addr;
    sq_len    = line_len;
    #1;
    while (!sq_ready) begin
      @(negedge nclk);
      #1;
    end
    @(negedge nclk);
    sq_valid = 1'b0;
    #1;
    checks = checks + 1;
    if (!tx_valid) begin
      $display("** Error test %0d: tx_valid not high one cycle after sq acceptance", cur_test);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic push_rx_word();
    logic keep;
    @(negedge nclk);
    drive_idle();
    rx_valid = 1'b1;
    rx_data  = build_word(line_opc[4:0], line_qpn[1:0], line_psn, '0);
    #1;
    while (!rx_ready) begin
      @(negedge nclk);
      #1;
    end
    keep = (line_opc[4:0] == 5'd17) && (line_psn == rx_psn[line_qpn[1:0]]);
    rx_cnt = rx_cnt + 1;
    if (keep) begin
      ack_q.push_back({line_qpn[1:0], line_psn});
      rx_psn[line_qpn[1:0]] = rx_psn[line_qpn[1:0]] + 1'b1;
    end else begin
      drop_cnt = drop_cnt + 1;
    end
    @(negedge nclk);
    rx_valid = 1'b0;
    #1;
    checks = checks + 1;
    if (!rx_pkt_count_valid) begin
      $display("** Error test %0d: rx count valid did not pulse", cur_test);
      test_errors = test_errors + 1;
    end
    if (rx_pkt_count_data != rx_cnt) report_value("rx count", rx_cnt, rx_pkt_count_data);
    if (psn_drop_count_valid != !keep) report_value("drop valid", !keep, psn_drop_count_valid);
    if (keep && !ack_valid) begin
      $display("** Error test %0d: ack_valid not high one cycle after rx", cur_test);
      test_errors = test_errors + 1;
    end
    if (!keep && ack_valid && ack_q.size() == 0) begin
      $display("** Error test %0d: dropped rx word raised ack_valid", cur_test);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic take_tx();
    net_word_t exp;
    logic      done;
    logic      bad;
    exp  = build_word(line_opc[4:0], line_qpn[1:0], tx_psn[line_qpn[1:0]], line_len);
    done = 1'b0;
    bad  = 1'b0;
    @(negedge nclk);
    drive_idle();
    while (!done) begin
      tx_ready = sink_ready();
      #1;
      // Held data must match through every stall
      if (tx_valid && tx_data != exp && !bad) begin
        report_value("tx_data", exp, tx_data);
        bad = 1'b1;
      end
      done = tx_valid & tx_ready;
      @(negedge nclk);
    end
    tx_ready = 1'b0;
    tx_cnt = tx_cnt + 1;
    tx_psn[line_qpn[1:0]] = tx_psn[line_qpn[1:0]] + 1'b1;
    #1;
    checks = checks + 1;
    if (!tx_pkt_count_valid) begin
      $display("** Error test %0d: tx count valid did not pulse", cur_test);
      test_errors = test_errors + 1;
    end
    if (tx_pkt_count_data != tx_cnt) report_value("tx count", tx_cnt, tx_pkt_count_data);
  endtask

  task automatic take_ack();
    logic [25:0] exp;
    logic        done;
    logic        bad;
    done = 1'b0;
    bad  = 1'b0;
    checks = checks + 1;
    if (ack_q.size() == 0) begin
      $display("** Error test %0d: vector waits for an ack the model never produced", cur_test);
      test_errors = test_errors + 1;
      return;
    end
    exp = ack_q.pop_front();
    @(negedge nclk);
    drive_idle();
    while (!done) begin
      ack_ready = sink_ready();
      #1;
      if (ack_valid && {ack_qpn, ack_psn} != exp && !bad) begin
        report_value("ack qpn/psn", exp, {ack_qpn, ack_psn});
        bad = 1'b1;
      end
      done = ack_valid & ack_ready;
      @(negedge nclk);
    end
    ack_ready = 1'b0;
  endtask

  task automatic check_sq_level();
    @(negedge nclk);
    drive_idle();
    #1;
    checks = checks + 1;
    if (sq_ready != line_psn[0]) report_value("sq_ready", line_psn[0], sq_ready);
  endtask

  task automatic compare_counters();
    @(negedge nclk);
    drive_idle();
    #1;
    checks = checks + 1;
    if (tx_pkt_count_data != tx_cnt) report_value("tx packets", tx_cnt, tx_pkt_count_data);
    if (rx_pkt_count_data != rx_cnt) report_value("rx packets", rx_cnt, rx_pkt_count_data);
    if (psn_drop_count_data != drop_cnt) begin
      report_value("psn drops", drop_cnt, psn_drop_count_data);
    end
    if (tx_valid || ack_valid) begin
      $display("** Error test %0d: tx or ack word left over after the last step", cur_test);
      test_errors = test_errors + 1;
    end
    if (ack_q.size() != 0) begin
      $display("** Error test %0d: %0d model acks were never taken", cur_test, ack_q.size());
      test_errors = test_errors + 1;
    end
    if (tx_pkt_count_valid || rx_pkt_count_valid || psn_drop_count_valid) begin
      $display("** Error test %0d: counter valid high with no traffic", cur_test);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic close_test();
    $display("test %0d finished with %0d errors", cur_test, test_errors);
    errors = errors + test_errors;
    test_errors = 0;
    tests_run = tests_run + 1;
  endtask

  initial begin
    nclk = 1'b0;
    arst_n = 1'b0;
    sq_opcode = RC_SEND;
    sq_qpn = '0;
    sq_vaddr = '0;
    sq_len = '0;
    rx_data = '0;
    drive_idle();
    cycles = 0;
    limit = 1000000;
    errors = 0;
    test_errors = 0;
    checks = 0;
    tests_run = 0;
    rng = 32'd97;
    tx_cnt = '0;
    rx_cnt = '0;
    drop_cnt = '0;
    line_test = '0;
    for (int i = 0; i < `ROCE_NUM_QP; i++) begin
      tx_psn[i] = '0;
      rx_psn[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      vec[i] = '0;
    end
    $readmemh("verification/roce_vectors.txt", vec);
    nlines = 0;
    while (nlines < 64 && vec[nlines][95:92] != 4'd0) begin
      nlines = nlines + 1;
    end
    if (nlines == 0) begin
      $display("No vector lines were read from the vector file");
      errors = errors + 1;
    end
    limit = 40 * nlines + 16;
    cur_test = vec[0][7:0];
    repeat (16) @(posedge nclk);
    @(negedge nclk);
    arst_n = 1'b1;
    for (int i = 0; i < nlines; i++) begin
      {line_kind, line_opc, line_qpn, line_psn, line_len, line_addr, line_test} = vec[i];
      if (line_test != cur_test) begin
        close_test();
        cur_test = line_test;
      end
      case (line_kind)
        4'd1: send_request();
        4'd2: push_rx_word();
        4'd3: take_tx();
        4'd4: take_ack();
        4'd5: compare_counters();
        4'd6: check_sq_level();
        default: begin
          $display("Unknown step kind %0d on vector line %0d", line_kind, i);
          test_errors = test_errors + 1;
        end
      endcase
    end
    close_test();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/roce_vectors.txt
// kind_opcode_qpn_psn_len_addr_test, all hex
// kind 1 send, 2 rx word, 3 expect tx, 4 expect ack, 5 counters, 6 sq_ready level in psn
1_00_0_000000_0040_00001000_01
3_00_0_000000_0040_00000000_01
1_0a_2_000000_0100_00002000_01
3_0a_2_000000_0100_00000000_01
1_0c_0_000000_0020_00003000_01
3_0c_0_000000_0020_00000000_01
1_0a_0_000000_0008_00004000_01
3_0a_0_000000_0008_00000000_01
2_11_0_000000_0000_00000000_02
4_00_0_000000_0000_00000000_02
2_11_0_000001_0000_00000000_02
4_00_0_000000_0000_00000000_02
2_11_0_000005_0000_00000000_03
2_00_0_000002_0000_00000000_03
2_11_2_000001_0000_00000000_03
2_11_0_000002_0000_00000000_03
4_00_0_000000_0000_00000000_03
1_00_2_000000_0010_00005000_04
3_00_2_000000_0010_00000000_04
1_0a_1_000000_0200_00006000_04
3_0a_1_000000_0200_00000000_04
1_0c_3_000000_0004_00007000_04
3_0c_3_000000_0004_00000000_04
6_00_0_000000_0000_00000000_04
2_11_2_000000_0000_00000000_04
4_00_0_000000_0000_00000000_04
6_00_0_000001_0000_00000000_04
1_00_2_000000_0033_00008000_05
3_00_2_000000_0033_00000000_05
2_11_2_000001_0000_00000000_05
4_00_0_000000_0000_00000000_05
2_11_1_000000_0000_00000000_05
4_00_0_000000_0000_00000000_05
2_11_3_000000_0000_00000000_05
4_00_0_000000_0000_00000000_05
2_11_2_000002_0000_00000000_05
4_00_0_000000_0000_00000000_05
1_0c_1_000000_0080_00009000_05
3_0c_1_000000_0080_00000000_05
2_11_1_000001_0000_00000000_05
4_00_0_000000_0000_00000000_05
5_00_0_000000_0000_00000000_06

//--- list.f
+incdir+verilog
verilog/roce_pkg.sv
verilog/rdma_flow.sv
verilog/roce_tx_engine.sv
verilog/roce_rx_engine.sv
verilog/roce_stack.sv
verification/roce_stack_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RoCE stack testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module roce_stack_tb \
  -o sim_roce > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  cat build.log
  exit 1
fi

./obj_dir/sim_roce > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
